//--- rtl/npu_buf_pkg.sv
//----------------------------
// Widths and APB map shared by the buffer subsystem
// Line address is ROW_AW+1 bits, bank in the MSB, row below
// Addresses wrap modulo two banks of 2**ROW_AW lines
//----------------------------
package npu_buf_pkg;

  localparam int WORD_W         = 32;  // Stream and APB data
  localparam int WORDS_PER_LINE = 4;
  localparam int LINE_W         = WORD_W * WORDS_PER_LINE;
  localparam int WSEL_W         = $clog2(WORDS_PER_LINE);  // Word index in a line
  localparam int APB_AW         = 8;
  localparam int CNT_W          = 16;  // Line count registers

  // APB register offsets
  localparam logic [APB_AW-1:0] REG_CTRL      = 8'h00;  // bit0 dma_start, bit1 rd_start
  localparam logic [APB_AW-1:0] REG_DMA_DST   = 8'h04;
  localparam logic [APB_AW-1:0] REG_DMA_LINES = 8'h08;
  localparam logic [APB_AW-1:0] REG_RD_SRC    = 8'h0C;
  localparam logic [APB_AW-1:0] REG_RD_LINES  = 8'h10;
  localparam logic [APB_AW-1:0] REG_STATUS    = 8'h14;

  // Line address word, one value seen two ways
  //   idx    flat line index, what the DMA and reader count with
  //   f.bank selects the bank, top bit of idx
  //   f.row  row inside that bank
  // Declared as gbuf_line_addr_u in gbuf_if since its width follows ROW_AW

endpackage

//--- rtl/gbuf_if.sv
//----------------------------
// One line-wide access port into the global buffer
// Access happens when cs and gnt are both high
// Read data valid one cycle after a granted read
//----------------------------
`timescale 1ns/100ps

interface gbuf_if import npu_buf_pkg::*; #(
  parameter int ROW_AW = 8
);

  typedef struct packed {
    logic              bank;
    logic [ROW_AW-1:0] row;
  } gbuf_bank_row_t;

  typedef union packed {
    logic [ROW_AW:0] idx;  // Flat line index
    gbuf_bank_row_t  f;    // Bank and row decode
  } gbuf_line_addr_u;

  logic              cs;
  logic              we;
  gbuf_line_addr_u   addr;
  logic [LINE_W-1:0] wdata;
  logic [LINE_W-1:0] rdata;
  logic              gnt;   // Combinational, from the buffer side

  modport requester (output cs, we, addr, wdata, input rdata, gnt);
  modport buffer    (input cs, we, addr, wdata, output rdata, gnt);

endinterface

//--- rtl/dma_cfg_apb.sv
//----------------------------
// APB slave without wait states, no PREADY/PSLVERR
// Start bits are write-one pulses, done bits write-one-clear
// Unmapped offsets read zero
//----------------------------
`timescale 1ns/100ps

module dma_cfg_apb import npu_buf_pkg::*; #(
  parameter int ROW_AW = 8
) (
  input  logic              xclk,
  input  logic              i_reset,
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [APB_AW-1:0] i_paddr,
  input  logic [WORD_W-1:0] i_pwdata,
  output logic [WORD_W-1:0] o_prdata,
  output logic              o_dma_start,
  output logic              o_rd_start,
  output logic [ROW_AW:0]   o_dma_dst,
  output logic [ROW_AW:0]   o_rd_src,
  output logic [CNT_W-1:0]  o_dma_lines,
  output logic [CNT_W-1:0]  o_rd_lines,
  input  logic              i_dma_busy,
  input  logic              i_rd_busy,
  input  logic              i_dma_fin,
  input  logic              i_rd_fin,
  output logic              o_irq
);

  logic              wr_en;
  logic              rd_setup;
  logic              dma_done_q;
  logic              rd_done_q;
  logic [WORD_W-1:0] rd_mux;

  assign wr_en    = i_psel && i_penable && i_pwrite;  // Access phase
  assign rd_setup = i_psel && !i_penable && !i_pwrite;

  always_comb begin
    case (i_paddr)
      REG_DMA_DST:   rd_mux = WORD_W'(o_dma_dst);
      REG_DMA_LINES: rd_mux = WORD_W'(o_dma_lines);
      REG_RD_SRC:    rd_mux = WORD_W'(o_rd_src);
      REG_RD_LINES:  rd_mux = WORD_W'(o_rd_lines);
      REG_STATUS:    rd_mux = WORD_W'({rd_done_q, i_rd_busy, dma_done_q, i_dma_busy});
      default:       rd_mux = '0;  // CTRL included
    endcase
  end

  always_ff @(posedge xclk) begin
    if (i_reset) begin
      o_prdata    <= '0;
      o_dma_start <= 1'b0;
      o_rd_start  <= 1'b0;
      o_dma_dst   <= '0;
      o_rd_src    <= '0;
      o_dma_lines <= '0;
      o_rd_lines  <= '0;
      dma_done_q  <= 1'b0;
      rd_done_q   <= 1'b0;
    end else begin
      if (rd_setup) o_prdata <= rd_mux;  // Ready for the access phase
      o_dma_start <= wr_en && (i_paddr == REG_CTRL) && i_pwdata[0];
      o_rd_start  <= wr_en && (i_paddr == REG_CTRL) && i_pwdata[1];
      if (wr_en) begin
        case (i_paddr)
          REG_DMA_DST:   o_dma_dst   <= i_pwdata[ROW_AW:0];
          REG_DMA_LINES: o_dma_lines <= i_pwdata[CNT_W-1:0];
          REG_RD_SRC:    o_rd_src    <= i_pwdata[ROW_AW:0];
          REG_RD_LINES:  o_rd_lines  <= i_pwdata[CNT_W-1:0];
          default: ;
        endcase
      end
      // Finish wins over a clear in the same cycle
      if (i_dma_fin) dma_done_q <= 1'b1;
      else if (wr_en && (i_paddr == REG_STATUS) && i_pwdata[1]) dma_done_q <= 1'b0;
      if (i_rd_fin) rd_done_q <= 1'b1;
      else if (wr_en && (i_paddr == REG_STATUS) && i_pwdata[3]) rd_done_q <= 1'b0;
    end
  end

  assign o_irq = dma_done_q || rd_done_q;

endmodule

//--- rtl/dma_wr_engine.sv
//----------------------------
// Packs four stream words into one buffer line, word 0 lowest
// Whole-line writes only, DMA port is never refused
// Start with zero lines finishes at once
//----------------------------
`timescale 1ns/100ps

module dma_wr_engine import npu_buf_pkg::*; #(
  parameter int ROW_AW = 8
) (
  input  logic              xclk,
  input  logic              i_reset,
  input  logic              i_start,
  input  logic [ROW_AW:0]   i_dst,
  input  logic [CNT_W-1:0]  i_lines,
  input  logic              i_in_valid,
  input  logic [WORD_W-1:0] i_in_data,
  output logic              o_in_ready,
  output logic              o_busy,
  output logic              o_fin,
  gbuf_if.requester         dma_port
);

  logic                                  rx_q;       // Taking stream words
  logic                                  wr_pend_q;  // Line write this cycle
  logic [WSEL_W-1:0]                     word_cnt_q;
  logic [WORDS_PER_LINE-2:0][WORD_W-1:0] pack_q;
  logic [LINE_W-1:0]                     line_q;
  logic [CNT_W-1:0]                      lines_left_q;
  logic [ROW_AW:0]                       addr_q;
  logic                                  start_ok;
  logic                                  take;
  logic                                  line_full;
  logic                                  last_wr;

  assign start_ok  = i_start && !o_busy;  // Start while busy is dropped
  assign take      = rx_q && i_in_valid;
  assign line_full = take && (word_cnt_q == WSEL_W'(WORDS_PER_LINE - 1));
  assign last_wr   = wr_pend_q && (lines_left_q == CNT_W'(1));

  assign o_in_ready = rx_q;
  assign o_busy     = rx_q || wr_pend_q;
  assign o_fin      = last_wr || (start_ok && (i_lines == '0));

  assign dma_port.cs    = wr_pend_q;
  assign dma_port.we    = 1'b1;
  assign dma_port.addr  = addr_q;
  assign dma_port.wdata = line_q;

  always_ff @(posedge xclk) begin
    if (i_reset) begin
      rx_q         <= 1'b0;
      wr_pend_q    <= 1'b0;
      word_cnt_q   <= '0;
      lines_left_q <= '0;
      addr_q       <= '0;
    end else begin
      wr_pend_q <= line_full;
      if (start_ok && (i_lines != '0)) begin
        rx_q         <= 1'b1;
        word_cnt_q   <= '0;
        lines_left_q <= i_lines;
        addr_q       <= i_dst;
      end else begin
        if (take) begin
          word_cnt_q <= word_cnt_q + 1'b1;  // Wraps at a line boundary
          // Last line packed, stop taking words
          if (line_full && (lines_left_q == CNT_W'(1))) rx_q <= 1'b0;
        end
        if (wr_pend_q) begin
          lines_left_q <= lines_left_q - 1'b1;
          addr_q       <= addr_q + 1'b1;  // Wraps over both banks
        end
      end
    end
  end

  // Line register frees the pack register during the write
  always_ff @(posedge xclk) begin
    if (take && !line_full) pack_q[word_cnt_q] <= i_in_data;
    if (line_full) line_q <= {i_in_data, pack_q};
  end

endmodule

//--- rtl/gbuf_mux.sv
//----------------------------
// Two banks of 2**ROW_AW lines, one access per bank per cycle
// DMA port wins a bank clash, NPE port then loses gnt
// Read data registered per bank, one cycle latency
//----------------------------
`timescale 1ns/100ps

module gbuf_mux import npu_buf_pkg::*; #(
  parameter int ROW_AW = 8
) (
  input  logic   xclk,
  gbuf_if.buffer dma_port,
  gbuf_if.buffer npe_port
);

  localparam int ROWS = 1 << ROW_AW;

  logic [LINE_W-1:0] bank_rdata [2];
  logic              dma_sel_q;  // Bank of the last DMA read
  logic              npe_sel_q;

  assign dma_port.gnt = 1'b1;
  assign npe_port.gnt = !(dma_port.cs &&
                          (dma_port.addr.f.bank == npe_port.addr.f.bank));

  for (genvar b = 0; b < 2; b++) begin : g_bank
    logic [LINE_W-1:0] mem [ROWS];
    logic [LINE_W-1:0] rdata_q;
    logic              dma_hit;
    logic              npe_hit;
    logic              hit;
    logic              we;
    logic [ROW_AW-1:0] row;
    logic [LINE_W-1:0] wdata;

    assign dma_hit = dma_port.cs && (dma_port.addr.f.bank == 1'(b));
    assign npe_hit = npe_port.cs && (npe_port.addr.f.bank == 1'(b)) && !dma_hit;
    assign hit     = dma_hit || npe_hit;

    // Winning port drives the bank
    assign we    = dma_hit ? dma_port.we : npe_port.we;
    assign row   = dma_hit ? dma_port.addr.f.row : npe_port.addr.f.row;
    assign wdata = dma_hit ? dma_port.wdata : npe_port.wdata;

    always_ff @(posedge xclk) begin
      if (hit && we) mem[row] <= wdata;
      if (hit && !we) rdata_q <= mem[row];  // Holds over writes
    end

    assign bank_rdata[b] = rdata_q;
  end

  // Steer each port back to the bank it read
  always_ff @(posedge xclk) begin
    if (dma_port.cs && !dma_port.we) dma_sel_q <= dma_port.addr.f.bank;
    if (npe_port.cs && npe_port.gnt && !npe_port.we) begin
      npe_sel_q <= npe_port.addr.f.bank;
    end
  end

  assign dma_port.rdata = bank_rdata[dma_sel_q];
  assign npe_port.rdata = bank_rdata[npe_sel_q];

endmodule

//--- rtl/npe_line_reader.sv
//----------------------------
// Reads a line range and streams it out lowest word first
// At most one read in flight, one line held
// Start with zero lines finishes at once
//----------------------------
`timescale 1ns/100ps

module npe_line_reader import npu_buf_pkg::*; #(
  parameter int ROW_AW = 8
) (
  input  logic              xclk,
  input  logic              i_reset,
  input  logic              i_start,
  input  logic [ROW_AW:0]   i_src,
  input  logic [CNT_W-1:0]  i_lines,
  output logic              o_out_valid,
  output logic [WORD_W-1:0] o_out_data,
  input  logic              i_out_ready,
  output logic              o_busy,
  output logic              o_fin,
  gbuf_if.requester         npe_port
);

  logic                                  busy_q;
  logic                                  inflight_q;  // Granted read, data due now
  logic                                  hold_vld_q;
  logic [CNT_W-1:0]                      req_left_q;  // Lines not yet requested
  logic [WSEL_W-1:0]                     word_idx_q;
  logic [WORDS_PER_LINE-1:0][WORD_W-1:0] hold_q;
  logic [ROW_AW:0]                       addr_q;
  logic                                  start_ok;
  logic                                  accept;
  logic                                  last_take;
  logic                                  granted;

  assign start_ok  = i_start && !busy_q;
  assign accept    = hold_vld_q && i_out_ready;
  assign last_take = accept && (word_idx_q == WSEL_W'(WORDS_PER_LINE - 1));
  assign granted   = npe_port.cs && npe_port.gnt;

  // Ask only when the held line is gone or leaving
  assign npe_port.cs    = busy_q && (req_left_q != '0) && !inflight_q &&
                          (!hold_vld_q || last_take);
  assign npe_port.we    = 1'b0;
  assign npe_port.addr  = addr_q;
  assign npe_port.wdata = '0;

  assign o_out_valid = hold_vld_q;
  assign o_out_data  = hold_q[word_idx_q];
  assign o_busy      = busy_q;
  assign o_fin       = (last_take && (req_left_q == '0)) || (start_ok && (i_lines == '0));

  always_ff @(posedge xclk) begin
    if (i_reset) begin
      busy_q     <= 1'b0;
      inflight_q <= 1'b0;
      hold_vld_q <= 1'b0;
      req_left_q <= '0;
      word_idx_q <= '0;
      addr_q     <= '0;
    end else begin
      inflight_q <= granted;  // Denied request is simply retried
      if (start_ok && (i_lines != '0)) begin
        busy_q     <= 1'b1;
        req_left_q <= i_lines;
        addr_q     <= i_src;
      end else if (o_fin) begin
        busy_q <= 1'b0;
      end
      if (granted) begin
        req_left_q <= req_left_q - 1'b1;
        addr_q     <= addr_q + 1'b1;
      end
      if (inflight_q) begin
        hold_vld_q <= 1'b1;
        word_idx_q <= '0;
      end else if (accept) begin
        word_idx_q <= word_idx_q + 1'b1;
        if (last_take) hold_vld_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge xclk) begin
    if (inflight_q) hold_q <= npe_port.rdata;
  end

endmodule

//--- rtl/npu_buf_top.sv
//----------------------------
// APB-configured DMA into a two-bank buffer, read back to a stream
// ROW_AW sets rows per bank as a power of two
//----------------------------
`timescale 1ns/100ps

module npu_buf_top import npu_buf_pkg::*; #(
  parameter int ROW_AW = 8
) (
  input  logic              xclk,
  input  logic              i_reset,
  // APB
  input  logic              i_psel,
  input  logic              i_penable,
  input  logic              i_pwrite,
  input  logic [APB_AW-1:0] i_paddr,
  input  logic [WORD_W-1:0] i_pwdata,
  output logic [WORD_W-1:0] o_prdata,
  // Input stream
  input  logic              i_in_valid,
  input  logic [WORD_W-1:0] i_in_data,
  output logic              o_in_ready,
  // Output stream
  output logic              o_out_valid,
  output logic [WORD_W-1:0] o_out_data,
  input  logic              i_out_ready,
  output logic              o_irq
);

  logic             dma_start;
  logic             rd_start;
  logic [ROW_AW:0]  dma_dst;
  logic [ROW_AW:0]  rd_src;
  logic [CNT_W-1:0] dma_lines;
  logic [CNT_W-1:0] rd_lines;
  logic             dma_busy;
  logic             rd_busy;
  logic             dma_fin;
  logic             rd_fin;

  gbuf_if #(.ROW_AW(ROW_AW)) dma_port ();
  gbuf_if #(.ROW_AW(ROW_AW)) npe_port ();

  dma_cfg_apb #(.ROW_AW(ROW_AW)) u_cfg (
    .xclk        (xclk),
    .i_reset     (i_reset),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .o_dma_start (dma_start),
    .o_rd_start  (rd_start),
    .o_dma_dst   (dma_dst),
    .o_rd_src    (rd_src),
    .o_dma_lines (dma_lines),
    .o_rd_lines  (rd_lines),
    .i_dma_busy  (dma_busy),
    .i_rd_busy   (rd_busy),
    .i_dma_fin   (dma_fin),
    .i_rd_fin    (rd_fin),
    .o_irq       (o_irq)
  );

  dma_wr_engine #(.ROW_AW(ROW_AW)) u_dma (
    .xclk       (xclk),
    .i_reset    (i_reset),
    .i_start    (dma_start),
    .i_dst      (dma_dst),
    .i_lines    (dma_lines),
    .i_in_valid (i_in_valid),
    .i_in_data  (i_in_data),
    .o_in_ready (o_in_ready),
    .o_busy     (dma_busy),
    .o_fin      (dma_fin),
    .dma_port   (dma_port)
  );

  gbuf_mux #(.ROW_AW(ROW_AW)) u_gbuf (
    .xclk     (xclk),
    .dma_port (dma_port),
    .npe_port (npe_port)
  );

  npe_line_reader #(.ROW_AW(ROW_AW)) u_rd (
    .xclk        (xclk),
    .i_reset     (i_reset),
    .i_start     (rd_start),
    .i_src       (rd_src),
    .i_lines     (rd_lines),
    .o_out_valid (o_out_valid),
    .o_out_data  (o_out_data),
    .i_out_ready (i_out_ready),
    .o_busy      (rd_busy),
    .o_fin       (rd_fin),
    .npe_port    (npe_port)
  );

endmodule

//--- tb/tb_npu_buf.sv
//------------------------------
// Testbench for npu_buf_top, ROW_AW fixed at 8
// Random data from a fixed seed, checked against a line model
// Run stops at a cycle limit taken from the test lengths
//------------------------------
`timescale 1ns/100ps

module tb_npu_buf import npu_buf_pkg::*; ();

  localparam int ROW_AW      = 8;
  localparam int ADDR_N      = 1 << (ROW_AW + 1);  // Lines over both banks
  localparam int FILL_LINES  = 12;
  localparam int CONC_LINES  = 8;
  localparam int STAT_LINES  = 2;
  localparam int BUSY_LINES  = 4;
  localparam int TOTAL_LINES = 3 * FILL_LINES + 2 * (FILL_LINES + 2 * CONC_LINES) +
                               2 * STAT_LINES + 2 * BUSY_LINES;
  localparam int CYCLE_LIMIT = TOTAL_LINES * WORDS_PER_LINE * 8 + 2000;

  logic              xclk = 1'b0;
  logic              i_reset;
  logic              i_psel;
  logic              i_penable;
  logic              i_pwrite;
  logic [APB_AW-1:0] i_paddr;
  logic [WORD_W-1:0] i_pwdata;
  logic [WORD_W-1:0] o_prdata;
  logic              i_in_valid;
  logic [WORD_W-1:0] i_in_data;
  logic              o_in_ready;
  logic              o_out_valid;
  logic [WORD_W-1:0] o_out_data;
  logic              i_out_ready;
  logic              o_irq;

  logic [LINE_W-1:0] model [int];  // Expected buffer, by flat line index
  int                errors = 0;
  int                cycles = 0;
  int unsigned       seed_ret;

  npu_buf_top #(.ROW_AW(ROW_AW)) u_dut (
    .xclk        (xclk),
    .i_reset     (i_reset),
    .i_psel      (i_psel),
    .i_penable   (i_penable),
    .i_pwrite    (i_pwrite),
    .i_paddr     (i_paddr),
    .i_pwdata    (i_pwdata),
    .o_prdata    (o_prdata),
    .i_in_valid  (i_in_valid),
    .i_in_data   (i_in_data),
    .o_in_ready  (o_in_ready),
    .o_out_valid (o_out_valid),
    .o_out_data  (o_out_data),
    .i_out_ready (i_out_ready),
    .o_irq       (o_irq)
  );

  always #5 xclk = ~xclk;

  task automatic end_run();
    $display("Run complete, %0d error(s)", errors);
    if (errors == 0) $display("Everything OK");
    else $display("Something failed");
    $finish;
  endtask

  always @(posedge xclk) begin
    cycles = cycles + 1;
    if (cycles > CYCLE_LIMIT) begin
      $display("Error: run did not finish within %0d cycles", CYCLE_LIMIT);
      errors = errors + 1;
      end_run();
    end
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("Fail %s: expected %h, actual %h", name, exp, act);
      errors = errors + 1;
    end
  endtask

  // Setup, access, then idle
  task automatic apb_write(input logic [APB_AW-1:0] addr, input logic [31:0] data);
    @(posedge xclk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b1;
    i_paddr   <= addr;
    i_pwdata  <= data;
    @(posedge xclk);
    i_penable <= 1'b1;
    @(posedge xclk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b0;
  endtask

  task automatic apb_read(input logic [APB_AW-1:0] addr, output logic [31:0] data);
    @(posedge xclk);
    i_psel    <= 1'b1;
    i_penable <= 1'b0;
    i_pwrite  <= 1'b0;
    i_paddr   <= addr;
    @(posedge xclk);
    i_penable <= 1'b1;
    @(negedge xclk);
    data = o_prdata;  // Access phase
    @(posedge xclk);
    i_psel    <= 1'b0;
    i_penable <= 1'b0;
  endtask

  task automatic reg_roundtrip(input logic [APB_AW-1:0] addr, input logic [31:0] mask,
                               input string name);
    logic [31:0] v;
    logic [31:0] rd;
    v = $urandom;
    apb_write(addr, v);
    apb_read(addr, rd);
    check(name, v & mask, rd);
  endtask

  task automatic start_dma(input int dst, input int n);
    apb_write(REG_DMA_DST, dst);
    apb_write(REG_DMA_LINES, n);
    apb_write(REG_CTRL, 32'h1);
  endtask

  task automatic start_read(input int src, input int n);
    apb_write(REG_RD_SRC, src);
    apb_write(REG_RD_LINES, n);
    apb_write(REG_CTRL, 32'h2);
  endtask

  task automatic wait_done(input logic [31:0] mask);
    logic [31:0] st;
    st = '0;
    while ((st & mask) != mask) apb_read(REG_STATUS, st);
  endtask

  task automatic wait_and_clear(input logic [31:0] mask);
    wait_done(mask);
    apb_write(REG_STATUS, mask);
  endtask

  // New random lines into the model, then pushed as words with valid gaps
  task automatic feed_lines(input int dst, input int n);
    logic [WORD_W-1:0] words [$];
    logic [LINE_W-1:0] line;
    int                sent;
    for (int i = 0; i < n; i++) begin
      for (int w = 0; w < WORDS_PER_LINE; w++) line[w*WORD_W +: WORD_W] = $urandom;
      model[(dst + i) % ADDR_N] = line;
      for (int w = 0; w < WORDS_PER_LINE; w++) words.push_back(line[w*WORD_W +: WORD_W]);
    end
    sent = 0;
    while (sent < n * WORDS_PER_LINE) begin
      @(posedge xclk);
      i_in_valid <= ($urandom_range(3) != 0);
      i_in_data  <= words[sent];
      @(negedge xclk);
      if (i_in_valid && o_in_ready) sent++;
    end
    @(posedge xclk);
    i_in_valid <= 1'b0;
  endtask

  task automatic drain_lines(input int src, input int n, input bit rand_ready,
                             input string name);
    logic [LINE_W-1:0] line;
    int                got;
    got = 0;
    while (got < n * WORDS_PER_LINE) begin
      @(posedge xclk);
      i_out_ready <= rand_ready ? ($urandom_range(1) == 1) : 1'b1;
      @(negedge xclk);
      if (o_out_valid && i_out_ready) begin
        line = model[(src + got / WORDS_PER_LINE) % ADDR_N];
        check(name, line[(got % WORDS_PER_LINE)*WORD_W +: WORD_W], o_out_data);
        got++;
      end
    end
    @(posedge xclk);
    i_out_ready <= 1'b0;
  endtask

  initial begin
    logic [31:0] rd;
    int          src_a;
    int          dst_b;
    int          dst_c;
    int          dst_d;
    int          taken;
    seed_ret    = $urandom(32'h70d825e9);
    i_reset     = 1'b1;
    i_psel      = 1'b0;
    i_penable   = 1'b0;
    i_pwrite    = 1'b0;
    i_paddr     = '0;
    i_pwdata    = '0;
    i_in_valid  = 1'b0;
    i_in_data   = '0;
    i_out_ready = 1'b0;
    repeat (16) @(posedge xclk);
    i_reset <= 1'b0;

    // Register readback
    reg_roundtrip(REG_DMA_DST, ADDR_N - 1, "reg dma_dst");
    reg_roundtrip(REG_DMA_LINES, 32'hffff, "reg dma_lines");
    reg_roundtrip(REG_RD_SRC, ADDR_N - 1, "reg rd_src");
    reg_roundtrip(REG_RD_LINES, 32'hffff, "reg rd_lines");
    apb_write(REG_CTRL, $urandom & 32'hffff_fffc);  // Start bits left clear
    apb_read(REG_CTRL, rd);
    check("reg ctrl", 32'h0, rd);
    apb_write(8'h20, $urandom);
    apb_read(8'h20, rd);
    check("reg unmapped", 32'h0, rd);

    // Fill near the top so the range wraps into bank 0
    src_a = ADDR_N - 1 - $urandom_range(5);
    start_dma(src_a, FILL_LINES);
    feed_lines(src_a, FILL_LINES);
    wait_and_clear(32'h2);
    start_read(src_a, FILL_LINES);
    drain_lines(src_a, FILL_LINES, 1'b0, "fill read");
    wait_and_clear(32'h8);
    @(negedge xclk);
    check("fill read extra word", 32'h0, o_out_valid);

    // Same range under output back-pressure
    start_read(src_a, FILL_LINES);
    drain_lines(src_a, FILL_LINES, 1'b1, "backpressure read");
    wait_and_clear(32'h8);
    @(negedge xclk);
    check("backpressure extra word", 32'h0, o_out_valid);

    // Read range spans both banks, so each pass meets bank clashes
    for (int b = 0; b < 2; b++) begin
      dst_b = b * (ADDR_N / 2) + 32 + $urandom_range(63);
      apb_write(REG_DMA_DST, dst_b);
      apb_write(REG_DMA_LINES, CONC_LINES);
      apb_write(REG_RD_SRC, src_a);
      apb_write(REG_RD_LINES, FILL_LINES);
      apb_write(REG_CTRL, 32'h3);  // Both engines at once
      fork
        feed_lines(dst_b, CONC_LINES);
        drain_lines(src_a, FILL_LINES, 1'b1, "concurrent read");
      join
      wait_and_clear(32'ha);
      start_read(dst_b, CONC_LINES);
      drain_lines(dst_b, CONC_LINES, 1'b1, "concurrent fill");
      wait_and_clear(32'h8);
    end

    // Status bits and interrupt
    dst_c = $urandom_range(ADDR_N - 1);
    start_dma(dst_c, STAT_LINES);
    apb_read(REG_STATUS, rd);
    check("status dma busy", 32'h1, rd);
    feed_lines(dst_c, STAT_LINES);
    wait_done(32'h2);
    @(negedge xclk);
    check("irq after dma", 32'h1, o_irq);
    start_read(dst_c, STAT_LINES);  // Output held, reader stays busy
    apb_read(REG_STATUS, rd);
    check("status rd busy", 32'h6, rd);
    drain_lines(dst_c, STAT_LINES, 1'b1, "status read");
    wait_done(32'h8);
    apb_read(REG_STATUS, rd);
    check("status both done", 32'ha, rd);
    apb_write(REG_STATUS, 32'h2);
    apb_read(REG_STATUS, rd);
    check("status dma cleared", 32'h8, rd);
    @(negedge xclk);
    check("irq with rd done", 32'h1, o_irq);
    apb_write(REG_STATUS, 32'h8);
    apb_read(REG_STATUS, rd);
    check("status all cleared", 32'h0, rd);
    @(negedge xclk);
    check("irq cleared", 32'h0, o_irq);

    // Second start lands while the first transfer waits for words
    dst_d = $urandom_range(ADDR_N - 1);
    start_dma(dst_d, BUSY_LINES);
    start_dma((dst_d + 64) % ADDR_N, 7);
    feed_lines(dst_d, BUSY_LINES);
    taken = 0;
    repeat (16) begin
      @(posedge xclk);
      i_in_valid <= 1'b1;
      i_in_data  <= $urandom;
      @(negedge xclk);
      if (o_in_ready) taken++;
    end
    @(posedge xclk);
    i_in_valid <= 1'b0;
    check("words past first transfer", 32'h0, taken);
    wait_and_clear(32'h2);
    start_read(dst_d, BUSY_LINES);
    drain_lines(dst_d, BUSY_LINES, 1'b1, "start while busy read");
    wait_and_clear(32'h8);

    end_run();
  end

endmodule

//--- npu_buf.f
rtl/npu_buf_pkg.sv
rtl/gbuf_if.sv
rtl/dma_cfg_apb.sv
rtl/dma_wr_engine.sv
rtl/gbuf_mux.sv
rtl/npe_line_reader.sv
rtl/npu_buf_top.sv
tb/tb_npu_buf.sv

//--- Bender.yml
package:
  name: npu_buf

sources:
  - files:
      - rtl/npu_buf_pkg.sv
      - rtl/gbuf_if.sv
      - rtl/dma_cfg_apb.sv
      - rtl/dma_wr_engine.sv
      - rtl/gbuf_mux.sv
      - rtl/npe_line_reader.sv
      - rtl/npu_buf_top.sv
  - target: test
    files:
      - tb/tb_npu_buf.sv
